// File: src/scuBusPkg.sv
package scuBusPkg;

	typedef logic [24:0] cpuAddrT;
	typedef logic [26:0] busAddrT;
	typedef logic [31:0] wordT;
	typedef logic [15:0] halfT;
	typedef logic [25:0] aPinAddrT;

	// Active low, one bit per byte lane
	typedef logic [3:0] byteEnT;

	// SCU register window, decoded with ccs2N low
	localparam cpuAddrT regWinBase = 25'h1FE_0000;
	localparam cpuAddrT regWinLast = 25'h1FE_00CF;

	// ca[24:16] below this selects the A-bus under ccs2N
	localparam logic [8:0] aBusCs2Limit = 9'h190;

	// Prefixes in front of ca on the internal A-bus address
	localparam logic [1:0] aBusPrefixCs1 = 2'b01;
	localparam logic [1:0] aBusPrefixCs2 = 2'b10;

	typedef enum logic [2:0] {
		idle,
		chipSel,
		addr,
		read,
		write,
		finish
	} aBusStateT;

endpackage

// File: src/scuRegPkg.sv
package scuRegPkg;

	typedef logic [7:0] regOffsetT;
	typedef logic [19:0] countT;

	// Byte offsets inside the register window
	localparam regOffsetT offReadAddr  = 8'h00;
	localparam regOffsetT offWriteAddr = 8'h04;
	localparam regOffsetT offCount     = 8'h08;
	localparam regOffsetT offAddMode   = 8'h0C;
	localparam regOffsetT offEnable    = 8'h10;
	localparam regOffsetT offStatus    = 8'h7C;
	localparam regOffsetT offIntMask   = 8'hA0;
	localparam regOffsetT offIntStat   = 8'hA4;

	// Writable bits per register
	localparam logic [26:0] readAddrMask  = 27'h7FF_FFFF;
	localparam logic [26:0] writeAddrMask = 27'h7FF_FFFF;
	localparam logic [19:0] countMask     = 20'hF_FFFF;
	localparam logic [31:0] addModeMask   = 32'h0000_0101;
	localparam logic [31:0] enableMask    = 32'h0000_0101;
	localparam logic [31:0] intMaskMask   = 32'h0000_0800;
	localparam logic [31:0] intStatMask   = 32'h0000_0800;

	localparam int bitReadInc  = 8;
	localparam int bitWriteInc = 0;
	localparam int bitEnable   = 8;
	localparam int bitGo       = 0;
	localparam int bitBusy     = 4;
	localparam int bitDmaEnd   = 11;

	typedef enum logic [1:0] {
		idle,
		read,
		write,
		finish
	} dmaStateT;

endpackage

// File: src/scuIf.sv
`timescale 1ns/1ps

// Word transfer request towards an A-bus controller
interface aBusIf;
	scuBusPkg::busAddrT addr;
	scuBusPkg::wordT wdata;
	logic we;
	logic req;
	logic done;
	scuBusPkg::wordT rdata;

	modport master (
		output addr, wdata, we, req,
		input done, rdata
	);

	modport slave (
		input addr, wdata, we, req,
		output done, rdata
	);
endinterface

// CPU access into the register window
interface regBusIf;
	logic wr;
	logic rd;
	scuRegPkg::regOffsetT offset;
	scuBusPkg::wordT wdata;
	scuBusPkg::byteEnT byteEn;
	scuBusPkg::wordT rdata;

	modport host (
		output wr, rd, offset, wdata, byteEn,
		input rdata
	);

	modport target (
		input wr, rd, offset, wdata, byteEn,
		output rdata
	);
endinterface

// DMA channel parameters and run handshake
interface dmaCtrlIf;
	logic start;
	scuBusPkg::busAddrT readAddr;
	scuBusPkg::busAddrT writeAddr;
	scuRegPkg::countT count;
	logic readInc;
	logic writeInc;
	logic busy;
	logic done;

	modport cfg (
		output start, readAddr, writeAddr, count, readInc, writeInc,
		input busy, done
	);

	modport engine (
		input start, readAddr, writeAddr, count, readInc, writeInc,
		output busy, done
	);
endinterface

// File: src/scuCpuPort.sv
`timescale 1ns/1ps

module scuCpuPort (
	input  logic                CLK,
	input  logic                RST_N,
	input  scuBusPkg::cpuAddrT  ca,
	input  scuBusPkg::wordT     cdi,
	output scuBusPkg::wordT     cdo,
	input  logic                ccs1N,
	input  logic                ccs2N,
	input  logic                crdWrN,
	input  scuBusPkg::byteEnT   cdqmN,
	input  logic                crdN,
	output logic                cwaitN,
	regBusIf.host               regBus,
	aBusIf.master               cpuBus
);

	typedef enum logic [1:0] {
		cpuIdle,
		cpuAccess,
		cpuFinish
	} cpuStateT;

	cpuStateT state;
	logic cdqmIdleQ;
	logic crdNQ;
	logic cwe;
	logic cre;
	logic regSel;
	logic aBusSel;
	logic reqQ;
	logic waitQ;
	logic lastAbus;
	scuBusPkg::busAddrT addrQ;
	scuBusPkg::wordT wdataQ;
	logic weQ;
	scuBusPkg::wordT abRdata;

	// Strobes fire once per CPU access
	assign cwe = ~&cdqmN & cdqmIdleQ;
	assign cre = ~crdN & crdNQ;

	assign regSel = ~ccs2N & (ca >= scuBusPkg::regWinBase) & (ca <= scuBusPkg::regWinLast);
	assign aBusSel = ~ccs1N | (~ccs2N & (ca[24:16] < scuBusPkg::aBusCs2Limit));

	assign regBus.wr = regSel & cwe;
	assign regBus.rd = regSel & cre;
	assign regBus.offset = ca[7:0];
	assign regBus.wdata = cdi;
	assign regBus.byteEn = cdqmN;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cdqmIdleQ <= 1'b0;
			crdNQ <= 1'b0;
			state <= cpuIdle;
			reqQ <= 1'b0;
			waitQ <= 1'b0;
			lastAbus <= 1'b0;
		end else begin
			cdqmIdleQ <= &cdqmN;
			crdNQ <= crdN;
			if (regBus.rd) lastAbus <= 1'b0;
			case (state)
				cpuIdle: begin
					if (aBusSel) begin
						reqQ <= 1'b1;
						waitQ <= 1'b1;
						state <= cpuAccess;
					end
				end
				cpuAccess: begin
					if (cpuBus.done) begin
						reqQ <= 1'b0;
						waitQ <= 1'b0;
						if (!weQ) lastAbus <= 1'b1;
						state <= cpuFinish;
					end
				end
				// Hold until the CPU lets go of the select
				default: begin
					if (!aBusSel) state <= cpuIdle;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == cpuIdle && aBusSel) begin
			addrQ <= ccs1N ? {scuBusPkg::aBusPrefixCs2, ca} : {scuBusPkg::aBusPrefixCs1, ca};
			wdataQ <= cdi;
			weQ <= ~crdWrN;
		end
		if (state == cpuAccess && cpuBus.done && !weQ) begin
			abRdata <= cpuBus.rdata;
		end
	end

	assign cpuBus.addr = addrQ;
	assign cpuBus.wdata = wdataQ;
	assign cpuBus.we = weQ;
	assign cpuBus.req = reqQ;

	assign cwaitN = ~waitQ;
	assign cdo = lastAbus ? abRdata : regBus.rdata;

endmodule

// File: src/scuRegs.sv
`timescale 1ns/1ps

module scuRegs (
	input  logic CLK,
	input  logic RST_N,
	output logic irqN,
	regBusIf.target regBus,
	dmaCtrlIf.cfg dmaCtrl
);

	scuBusPkg::busAddrT readAddr;
	scuBusPkg::busAddrT writeAddr;
	scuRegPkg::countT count;
	logic readInc;
	logic writeInc;
	logic enable;
	logic go;
	logic intMask;
	logic endFlag;
	logic start;
	logic chanWr;
	scuBusPkg::wordT curWord;
	scuBusPkg::wordT wrMask;
	scuBusPkg::wordT merged;
	scuBusPkg::wordT rdataQ;

	function automatic scuBusPkg::wordT laneWrite(
		input scuBusPkg::wordT oldVal,
		input scuBusPkg::wordT newVal,
		input scuBusPkg::byteEnT byteEnN,
		input scuBusPkg::wordT mask
	);
		scuBusPkg::wordT result;
		result = oldVal;
		for (int i = 0; i < 4; i++) begin
			if (!byteEnN[i]) result[8*i +: 8] = newVal[8*i +: 8] & mask[8*i +: 8];
		end
		return result;
	endfunction

	// Current value of the addressed register and its merged write value
	always_comb begin
		curWord = '0;
		wrMask = '0;
		case (regBus.offset)
			scuRegPkg::offReadAddr: begin
				curWord = scuBusPkg::wordT'(readAddr);
				wrMask = scuBusPkg::wordT'(scuRegPkg::readAddrMask);
			end
			scuRegPkg::offWriteAddr: begin
				curWord = scuBusPkg::wordT'(writeAddr);
				wrMask = scuBusPkg::wordT'(scuRegPkg::writeAddrMask);
			end
			scuRegPkg::offCount: begin
				curWord = scuBusPkg::wordT'(count);
				wrMask = scuBusPkg::wordT'(scuRegPkg::countMask);
			end
			scuRegPkg::offAddMode: begin
				curWord[scuRegPkg::bitReadInc] = readInc;
				curWord[scuRegPkg::bitWriteInc] = writeInc;
				wrMask = scuRegPkg::addModeMask;
			end
			scuRegPkg::offEnable: begin
				curWord[scuRegPkg::bitEnable] = enable;
				curWord[scuRegPkg::bitGo] = go;
				wrMask = scuRegPkg::enableMask;
			end
			scuRegPkg::offStatus: curWord[scuRegPkg::bitBusy] = dmaCtrl.busy;
			scuRegPkg::offIntMask: begin
				curWord[scuRegPkg::bitDmaEnd] = intMask;
				wrMask = scuRegPkg::intMaskMask;
			end
			scuRegPkg::offIntStat: begin
				curWord[scuRegPkg::bitDmaEnd] = endFlag;
				wrMask = scuRegPkg::intStatMask;
			end
			default: ;
		endcase
		merged = laneWrite(curWord, regBus.wdata, regBus.byteEn, wrMask);
	end

	// Channel is locked while a copy runs
	assign chanWr = regBus.wr & ~dmaCtrl.busy;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			readAddr <= '0;
			writeAddr <= '0;
			count <= '0;
			readInc <= 1'b0;
			writeInc <= 1'b0;
			enable <= 1'b0;
			go <= 1'b0;
			intMask <= 1'b0;
			endFlag <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (chanWr) begin
				case (regBus.offset)
					scuRegPkg::offReadAddr: readAddr <= scuBusPkg::busAddrT'(merged);
					scuRegPkg::offWriteAddr: writeAddr <= scuBusPkg::busAddrT'(merged);
					scuRegPkg::offCount: count <= scuRegPkg::countT'(merged);
					scuRegPkg::offAddMode: begin
						readInc <= merged[scuRegPkg::bitReadInc];
						writeInc <= merged[scuRegPkg::bitWriteInc];
					end
					scuRegPkg::offEnable: begin
						enable <= merged[scuRegPkg::bitEnable];
						go <= merged[scuRegPkg::bitGo];
						start <= merged[scuRegPkg::bitEnable] & merged[scuRegPkg::bitGo];
					end
					default: ;
				endcase
			end
			if (regBus.wr && regBus.offset == scuRegPkg::offIntMask) begin
				intMask <= merged[scuRegPkg::bitDmaEnd];
			end
			// Writing 1 leaves the flag alone
			if (dmaCtrl.done) begin
				endFlag <= 1'b1;
			end else if (regBus.wr && regBus.offset == scuRegPkg::offIntStat) begin
				endFlag <= endFlag & merged[scuRegPkg::bitDmaEnd];
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (regBus.rd) rdataQ <= curWord;
	end

	assign regBus.rdata = rdataQ;

	assign dmaCtrl.start = start;
	assign dmaCtrl.readAddr = readAddr;
	assign dmaCtrl.writeAddr = writeAddr;
	assign dmaCtrl.count = count;
	assign dmaCtrl.readInc = readInc;
	assign dmaCtrl.writeInc = writeInc;

	assign irqN = ~(endFlag & ~intMask);

endmodule

// File: src/scuDmaEngine.sv
`timescale 1ns/1ps

module scuDmaEngine (
	input  logic CLK,
	input  logic RST_N,
	dmaCtrlIf.engine dmaCtrl,
	aBusIf.master dmaBus
);

	scuRegPkg::dmaStateT state;
	scuBusPkg::busAddrT readAddr;
	scuBusPkg::busAddrT writeAddr;
	scuRegPkg::countT remaining;
	scuBusPkg::wordT data;
	logic reqQ;
	logic busyQ;
	logic lastWord;

	assign lastWord = remaining == scuRegPkg::countT'(4);

	// Each state raises req once, then waits for done
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= scuRegPkg::idle;
			readAddr <= '0;
			writeAddr <= '0;
			remaining <= '0;
			reqQ <= 1'b0;
			busyQ <= 1'b0;
		end else begin
			case (state)
				scuRegPkg::idle: begin
					if (dmaCtrl.start) begin
						readAddr <= dmaCtrl.readAddr;
						writeAddr <= dmaCtrl.writeAddr;
						remaining <= dmaCtrl.count;
						busyQ <= 1'b1;
						state <= scuRegPkg::read;
					end
				end
				scuRegPkg::read: begin
					if (!reqQ) begin
						reqQ <= 1'b1;
					end else if (dmaBus.done) begin
						reqQ <= 1'b0;
						if (dmaCtrl.readInc) readAddr <= readAddr + scuBusPkg::busAddrT'(4);
						state <= scuRegPkg::write;
					end
				end
				scuRegPkg::write: begin
					if (!reqQ) begin
						reqQ <= 1'b1;
					end else if (dmaBus.done) begin
						reqQ <= 1'b0;
						if (dmaCtrl.writeInc) writeAddr <= writeAddr + scuBusPkg::busAddrT'(4);
						remaining <= remaining - scuRegPkg::countT'(4);
						if (lastWord) begin
							busyQ <= 1'b0;
							state <= scuRegPkg::finish;
						end else begin
							state <= scuRegPkg::read;
						end
					end
				end
				default: state <= scuRegPkg::idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == scuRegPkg::read && dmaBus.done) data <= dmaBus.rdata;
	end

	assign dmaBus.addr = (state == scuRegPkg::write) ? writeAddr : readAddr;
	assign dmaBus.we = state == scuRegPkg::write;
	assign dmaBus.wdata = data;
	assign dmaBus.req = reqQ;

	assign dmaCtrl.busy = busyQ;
	assign dmaCtrl.done = (state == scuRegPkg::write) & reqQ & dmaBus.done & lastWord;

endmodule

// File: src/scuBusArbiter.sv
`timescale 1ns/1ps

module scuBusArbiter (
	input  logic CLK,
	input  logic RST_N,
	aBusIf.slave cpuBus,
	aBusIf.slave dmaBus,
	aBusIf.master ctrlBus
);

	logic held;
	logic gntDma;
	logic selDma;
	logic ownerReq;

	// CPU wins while the bus is free
	assign selDma = held ? gntDma : ~cpuBus.req;
	assign ownerReq = selDma ? dmaBus.req : cpuBus.req;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			held <= 1'b0;
			gntDma <= 1'b0;
		end else if (!held && ownerReq) begin
			held <= 1'b1;
			gntDma <= selDma;
		end else if (held && !ownerReq) begin
			held <= 1'b0;
		end
	end

	assign ctrlBus.addr = selDma ? dmaBus.addr : cpuBus.addr;
	assign ctrlBus.wdata = selDma ? dmaBus.wdata : cpuBus.wdata;
	assign ctrlBus.we = selDma ? dmaBus.we : cpuBus.we;
	assign ctrlBus.req = ownerReq;

	assign cpuBus.done = ctrlBus.done & ~selDma;
	assign dmaBus.done = ctrlBus.done & selDma;
	assign cpuBus.rdata = ctrlBus.rdata;
	assign dmaBus.rdata = ctrlBus.rdata;

endmodule

// File: src/scuAbusCtrl.sv
`timescale 1ns/1ps

module scuAbusCtrl (
	input  logic                 CLK,
	input  logic                 RST_N,
	aBusIf.slave                 ctrlBus,
	output scuBusPkg::aPinAddrT  aa,
	input  scuBusPkg::halfT      adi,
	output scuBusPkg::halfT      ado,
	output logic                 aasN,
	output logic                 acs0N,
	output logic                 acs1N,
	output logic                 acs2N,
	input  logic                 awaitN,
	output logic                 ardN,
	output logic                 awrlN,
	output logic                 awruN
);

	scuBusPkg::aBusStateT state;
	logic lowHalf;
	logic doneQ;
	scuBusPkg::wordT rdataQ;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= scuBusPkg::idle;
			aasN <= 1'b1;
			acs0N <= 1'b1;
			acs1N <= 1'b1;
			acs2N <= 1'b1;
			ardN <= 1'b1;
			awrlN <= 1'b1;
			awruN <= 1'b1;
			lowHalf <= 1'b0;
			doneQ <= 1'b0;
		end else begin
			case (state)
				scuBusPkg::idle: begin
					if (ctrlBus.req) begin
						casez (ctrlBus.addr[26:24])
							3'b0??: acs0N <= 1'b0;
							3'b100: acs1N <= 1'b0;
							default: acs2N <= 1'b0;
						endcase
						state <= scuBusPkg::chipSel;
					end
				end
				scuBusPkg::chipSel: begin
					aasN <= 1'b0;
					lowHalf <= 1'b0;
					state <= scuBusPkg::addr;
				end
				scuBusPkg::addr: begin
					aasN <= 1'b1;
					if (ctrlBus.we) begin
						awrlN <= 1'b0;
						awruN <= 1'b0;
						state <= scuBusPkg::write;
					end else begin
						ardN <= 1'b0;
						state <= scuBusPkg::read;
					end
				end
				scuBusPkg::read, scuBusPkg::write: begin
					// Upper half first, each half ends on awaitN high
					if (awaitN) begin
						lowHalf <= 1'b1;
						if (lowHalf) begin
							ardN <= 1'b1;
							awrlN <= 1'b1;
							awruN <= 1'b1;
							acs0N <= 1'b1;
							acs1N <= 1'b1;
							acs2N <= 1'b1;
							doneQ <= 1'b1;
							state <= scuBusPkg::finish;
						end
					end
				end
				default: begin
					doneQ <= 1'b0;
					if (!ctrlBus.req) state <= scuBusPkg::idle;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == scuBusPkg::chipSel) begin
			aa <= ctrlBus.addr[25:0];
			ado <= ctrlBus.wdata[31:16];
		end
		if (state == scuBusPkg::write && awaitN && !lowHalf) begin
			ado <= ctrlBus.wdata[15:0];
		end
		if (state == scuBusPkg::read && awaitN) begin
			if (lowHalf) begin
				rdataQ[15:0] <= adi;
			end else begin
				rdataQ[31:16] <= adi;
			end
		end
	end

	assign ctrlBus.done = doneQ;
	assign ctrlBus.rdata = rdataQ;

endmodule

// File: src/scu.sv
`timescale 1ns/1ps

module scu (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  scuBusPkg::cpuAddrT   ca,
	input  scuBusPkg::wordT      cdi,
	output scuBusPkg::wordT      cdo,
	input  logic                 ccs1N,
	input  logic                 ccs2N,
	input  logic                 crdWrN,
	input  scuBusPkg::byteEnT    cdqmN,
	input  logic                 crdN,
	output logic                 cwaitN,
	output logic                 irqN,
	output scuBusPkg::aPinAddrT  aa,
	input  scuBusPkg::halfT      adi,
	output scuBusPkg::halfT      ado,
	output logic                 aasN,
	output logic                 acs0N,
	output logic                 acs1N,
	output logic                 acs2N,
	input  logic                 awaitN,
	output logic                 ardN,
	output logic                 awrlN,
	output logic                 awruN
);

	aBusIf cpuBus ();
	aBusIf dmaBus ();
	aBusIf ctrlBus ();
	regBusIf regBus ();
	dmaCtrlIf dmaCtrl ();

	scuCpuPort u_cpuPort (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.ca     (ca),
		.cdi    (cdi),
		.cdo    (cdo),
		.ccs1N  (ccs1N),
		.ccs2N  (ccs2N),
		.crdWrN (crdWrN),
		.cdqmN  (cdqmN),
		.crdN   (crdN),
		.cwaitN (cwaitN),
		.regBus (regBus.host),
		.cpuBus (cpuBus.master)
	);

	scuRegs u_regs (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.irqN    (irqN),
		.regBus  (regBus.target),
		.dmaCtrl (dmaCtrl.cfg)
	);

	scuDmaEngine u_dmaEngine (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.dmaCtrl (dmaCtrl.engine),
		.dmaBus  (dmaBus.master)
	);

	scuBusArbiter u_arbiter (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.cpuBus  (cpuBus.slave),
		.dmaBus  (dmaBus.slave),
		.ctrlBus (ctrlBus.master)
	);

	scuAbusCtrl u_abusCtrl (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.ctrlBus (ctrlBus.slave),
		.aa      (aa),
		.adi     (adi),
		.ado     (ado),
		.aasN    (aasN),
		.acs0N   (acs0N),
		.acs1N   (acs1N),
		.acs2N   (acs2N),
		.awaitN  (awaitN),
		.ardN    (ardN),
		.awrlN   (awrlN),
		.awruN   (awruN)
	);

endmodule

// File: verification/tbScu.sv
`timescale 1ns/1ps

module tbScu;

	localparam int clkPeriod = 4;
	// Cycle budget per test, in test order
	localparam int runCycles = 10 + 400 + 1000 + 800 + 800 + 1200;
	localparam logic [31:0] seed = 32'h6d22_60e0;

	logic CLK = 1'b0;
	logic RST_N;
	logic [24:0] ca;
	logic [31:0] cdi;
	logic [31:0] cdo;
	logic ccs1N;
	logic ccs2N;
	logic crdWrN;
	logic [3:0] cdqmN;
	logic crdN;
	logic cwaitN;
	logic irqN;
	logic [25:0] aa;
	logic [15:0] adi;
	logic [15:0] ado;
	logic aasN;
	logic acs0N;
	logic acs1N;
	logic acs2N;
	logic awaitN;
	logic ardN;
	logic awrlN;
	logic awruN;

	logic [31:0] stimSeed;
	int errors;
	int checks;
	int testsRun;
	int errAtStart;
	logic [31:0] busMem [logic [25:0]];
	logic [31:0] refMem [logic [25:0]];
	logic [2:0] lastCs;
	logic [25:0] copyDst;
	logic copyDstInc;
	int copyWords;

	always #(clkPeriod / 2) CLK = ~CLK;

	scu u_scu (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.ca     (ca),
		.cdi    (cdi),
		.cdo    (cdo),
		.ccs1N  (ccs1N),
		.ccs2N  (ccs2N),
		.crdWrN (crdWrN),
		.cdqmN  (cdqmN),
		.crdN   (crdN),
		.cwaitN (cwaitN),
		.irqN   (irqN),
		.aa     (aa),
		.adi    (adi),
		.ado    (ado),
		.aasN   (aasN),
		.acs0N  (acs0N),
		.acs1N  (acs1N),
		.acs2N  (acs2N),
		.awaitN (awaitN),
		.ardN   (ardN),
		.awrlN  (awrlN),
		.awruN  (awruN)
	);

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] stimRand();
		stimSeed = lcgStep(stimSeed);
		return stimSeed;
	endfunction

	// Pattern seen in words nobody has written yet
	function automatic logic [31:0] fillWord(input logic [25:0] a);
		return {6'h2B, a} ^ {a[15:0], a[25:10]};
	endfunction

	function automatic logic [31:0] busPeek(input logic [25:0] a);
		if (busMem.exists(a)) begin
			return busMem[a];
		end else begin
			return fillWord(a);
		end
	endfunction

	function automatic logic [31:0] refPeek(input logic [25:0] a);
		if (refMem.exists(a)) begin
			return refMem[a];
		end else begin
			return fillWord(a);
		end
	endfunction

	function automatic logic [7:0] regOffset(input int idx);
		case (idx)
			0: return 8'h00;
			1: return 8'h04;
			2: return 8'h08;
			3: return 8'h0C;
			default: return 8'hA0;
		endcase
	endfunction

	function automatic logic [31:0] regMask(input int idx);
		case (idx)
			0: return 32'h07FF_FFFF;
			1: return 32'h07FF_FFFF;
			2: return 32'h000F_FFFF;
			3: return 32'h0000_0101;
			default: return 32'h0000_0800;
		endcase
	endfunction

	// {acs2N, acs1N, acs0N} expected for a CPU access
	function automatic logic [2:0] csFor(input logic cs2, input logic [24:0] addr);
		if (!cs2) return 3'b110;
		return addr[24] ? 3'b011 : 3'b101;
	endfunction

	// A-bus memory, data halves move on cycles with awaitN high
	initial begin
		logic [31:0] busSeed;
		logic [31:0] word;
		logic [25:0] curAddr;
		logic [15:0] upperHalf;
		int halfIdx;
		busSeed = seed;
		curAddr = '0;
		upperHalf = '0;
		halfIdx = 0;
		lastCs = 3'b111;
		adi = '0;
		awaitN = 1'b1;
		forever begin
			@(posedge CLK);
			#1;
			busSeed = lcgStep(busSeed);
			awaitN = busSeed[31:30] != 2'b00;
			if (aasN === 1'b0) begin
				curAddr = aa;
				halfIdx = 0;
				lastCs = {acs2N, acs1N, acs0N};
			end
			if (ardN === 1'b0) begin
				word = busPeek(curAddr);
				adi = (halfIdx == 0) ? word[31:16] : word[15:0];
				if (awaitN) halfIdx++;
			end else if (awrlN === 1'b0 && awruN === 1'b0 && awaitN) begin
				if (halfIdx == 0) begin
					upperHalf = ado;
				end else begin
					busMem[curAddr] = {upperHalf, ado};
				end
				halfIdx++;
			end
		end
	end

	initial begin
		#(runCycles * 2 * clkPeriod);
		$display("watchdog expired after %0d cycles, the run did not complete", runCycles * 2);
		$display("tests failed");
		$finish;
	end

	task automatic tick();
		@(posedge CLK);
		#1;
	endtask

	task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic noteFailure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors == errAtStart) begin
			$display("PASS  %s", name);
		end else begin
			$display("FAIL  %s (%0d errors)", name, errors - errAtStart);
		end
		errAtStart = errors;
	endtask

	task automatic regWrite(input logic [7:0] off, input logic [31:0] data,
			input logic [3:0] lanesN);
		ca = {17'h1FE00, off};
		cdi = data;
		cdqmN = lanesN;
		crdWrN = 1'b0;
		ccs2N = 1'b0;
		tick();
		cdqmN = 4'hF;
		crdWrN = 1'b1;
		ccs2N = 1'b1;
		tick();
	endtask

	task automatic regRead(input logic [7:0] off, output logic [31:0] data);
		ca = {17'h1FE00, off};
		ccs2N = 1'b0;
		crdN = 1'b0;
		tick();
		tick();
		data = cdo;
		crdN = 1'b1;
		ccs2N = 1'b1;
		tick();
	endtask

	task automatic busAccess(input logic cs2, input logic [24:0] addr, input logic isWrite,
			input logic [31:0] data, output logic [31:0] rdata);
		int n;
		ca = addr;
		cdi = data;
		crdWrN = ~isWrite;
		crdN = isWrite;
		ccs1N = cs2;
		ccs2N = ~cs2;
		tick();
		if (cwaitN !== 1'b0) noteFailure("cwaitN did not go low one cycle after select");
		n = 0;
		while (cwaitN !== 1'b1 && n < 200) begin
			tick();
			n++;
		end
		if (cwaitN !== 1'b1) noteFailure("cwaitN stayed low for 200 cycles");
		rdata = cdo;
		ccs1N = 1'b1;
		ccs2N = 1'b1;
		crdWrN = 1'b1;
		crdN = 1'b1;
		tick();
	endtask

	task automatic cpuWrite(input logic cs2, input logic [24:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		refMem[{~cs2, addr}] = data;
		busAccess(cs2, addr, 1'b1, data, rdata);
	endtask

	task automatic cpuReadCheck(input logic cs2, input logic [24:0] addr);
		logic [31:0] got;
		busAccess(cs2, addr, 1'b0, 32'h0, got);
		expectEq($sformatf("cdo from aa 0x%07h", {~cs2, addr}), got, refPeek({~cs2, addr}));
	endtask

	task automatic startCopy(input logic [26:0] rA, input logic [26:0] wA, input int words,
			input logic rInc, input logic wInc);
		logic [25:0] src;
		logic [25:0] dst;
		src = rA[25:0];
		dst = wA[25:0];
		// Word order matches a read then write per word
		for (int k = 0; k < words; k++) begin
			refMem[dst] = refPeek(src);
			if (rInc) src = src + 26'd4;
			if (wInc) dst = dst + 26'd4;
		end
		copyDst = wA[25:0];
		copyDstInc = wInc;
		copyWords = words;
		regWrite(8'h00, 32'(rA), 4'h0);
		regWrite(8'h04, 32'(wA), 4'h0);
		regWrite(8'h08, 32'(words * 4), 4'h0);
		regWrite(8'h0C, {23'b0, rInc, 7'b0, wInc}, 4'h0);
		regWrite(8'h10, 32'h0000_0101, 4'h0);
	endtask

	task automatic checkCopy();
		logic [25:0] dst;
		dst = copyDst;
		for (int k = 0; k < copyWords; k++) begin
			expectEq($sformatf("word at aa 0x%07h", dst), busPeek(dst), refPeek(dst));
			if (copyDstInc) dst = dst + 26'd4;
		end
	endtask

	task automatic waitIrqLow();
		int n;
		n = 0;
		while (irqN !== 1'b0 && n < 3000) begin
			tick();
			n++;
		end
		if (irqN !== 1'b0) noteFailure("irqN did not fall within 3000 cycles of the DMA start");
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] got;
		logic [3:0] lanes;
		logic [8:0] hi9;
		logic [31:0] regModel [5];
		logic [24:0] addrs [12];
		logic sel2 [12];
		int idx;
		int n;
		stimSeed = seed;
		errors = 0;
		checks = 0;
		testsRun = 0;
		errAtStart = 0;
		RST_N = 1'b0;
		ca = '0;
		cdi = '0;
		ccs1N = 1'b1;
		ccs2N = 1'b1;
		crdWrN = 1'b1;
		cdqmN = 4'hF;
		crdN = 1'b1;
		for (int i = 0; i < 5; i++) regModel[i] = '0;
		repeat (2) @(posedge CLK);
		#1;
		RST_N = 1'b1;

		expectEq("cwaitN irqN aasN acs0N acs1N acs2N ardN awrlN awruN",
			{23'b0, cwaitN, irqN, aasN, acs0N, acs1N, acs2N, ardN, awrlN, awruN}, 32'h1FF);
		tick();
		finishTest("reset state");

		for (int i = 0; i < 30; i++) begin
			idx = int'((stimRand() >> 16) % 32'd5);
			data = stimRand();
			r = stimRand();
			lanes = r[31:28];
			if (lanes == 4'hF) lanes = 4'h0;
			regWrite(regOffset(idx), data, lanes);
			for (int b = 0; b < 4; b++) begin
				if (!lanes[b]) regModel[idx][8*b +: 8] = data[8*b +: 8];
			end
			regRead(regOffset(idx), got);
			expectEq($sformatf("register 0x%02h", regOffset(idx)), got,
				regModel[idx] & regMask(idx));
		end
		finishTest("register byte-lane writes");

		// Even entries go through ccs1N, odd ones through ccs2N
		for (int i = 0; i < 12; i++) begin
			r = stimRand();
			sel2[i] = (i % 2) == 1;
			hi9 = 9'((r >> 16) % 32'h190);
			addrs[i] = sel2[i] ? {hi9, r[29:16], 2'b00} : {r[31:9], 2'b00};
			cpuWrite(sel2[i], addrs[i], stimRand());
			expectEq("chip select on write", 32'(lastCs), 32'(csFor(sel2[i], addrs[i])));
		end
		for (int i = 0; i < 12; i++) begin
			cpuReadCheck(sel2[i], addrs[i]);
			expectEq("chip select on read", 32'(lastCs), 32'(csFor(sel2[i], addrs[i])));
		end
		finishTest("CPU A-bus writes and reads");

		regWrite(8'hA0, 32'h0, 4'h0);
		r = stimRand();
		data = stimRand();
		got = stimRand();
		startCopy(27'h010_0000 + 27'({r[27:18], 2'b00}), 27'h020_0000 + 27'({data[27:18], 2'b00}),
			1 + int'((got >> 16) % 32'd12), got[31], got[30]);
		waitIrqLow();
		checkCopy();
		regRead(8'hA4, got);
		expectEq("interrupt status", got, 32'h0000_0800);
		regWrite(8'hA4, 32'h0, 4'h0);
		expectEq("irqN after clear", 32'(irqN), 32'd1);
		finishTest("DMA copy with interrupt");

		regWrite(8'hA0, 32'h0000_0800, 4'h0);
		r = stimRand();
		got = stimRand();
		startCopy(27'h030_0000 + 27'({r[27:18], 2'b00}), 27'h040_0000 + 27'({r[15:6], 2'b00}),
			1 + int'((got >> 16) % 32'd12), got[31], got[30]);
		got = 32'h10;
		n = 0;
		while (got[4] && n < 400) begin
			regRead(8'h7C, got);
			expectEq("irqN while masked", 32'(irqN), 32'd1);
			n++;
		end
		if (got[4]) noteFailure("DMA busy did not clear within 400 status reads");
		checkCopy();
		regRead(8'hA4, got);
		expectEq("interrupt status", got, 32'h0000_0800);
		regWrite(8'hA4, 32'h0, 4'h0);
		regRead(8'hA4, got);
		expectEq("interrupt status after clear", got, 32'h0);
		regWrite(8'hA0, 32'h0, 4'h0);
		expectEq("irqN after unmask", 32'(irqN), 32'd1);
		finishTest("masked DMA end");

		for (int i = 0; i < 4; i++) begin
			addrs[i] = 25'h030_0000 + 25'(i * 4);
			cpuWrite(1'b0, addrs[i], stimRand());
		end
		r = stimRand();
		startCopy(27'h050_0000 + 27'({r[27:18], 2'b00}), 27'h060_0000 + 27'({r[15:6], 2'b00}),
			16, 1'b1, 1'b1);
		// These reads compete with the running copy
		for (int i = 0; i < 8; i++) cpuReadCheck(1'b0, addrs[i % 4]);
		waitIrqLow();
		checkCopy();
		regRead(8'hA4, got);
		expectEq("interrupt status", got, 32'h0000_0800);
		regWrite(8'hA4, 32'h0, 4'h0);
		finishTest("CPU reads during DMA");

		$display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: scu.f
src/scuBusPkg.sv
src/scuRegPkg.sv
src/scuIf.sv
src/scuCpuPort.sv
src/scuRegs.sv
src/scuDmaEngine.sv
src/scuBusArbiter.sv
src/scuAbusCtrl.sv
src/scu.sv
verification/tbScu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SCU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --top-module tbScu -f scu.f -Mdir build -o simScu

./build/simScu | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished clean"
